/* apb_access_decode.sv */
// Zero wait-state APB decode; STATUS writes flag PSLVERR yet still clear the done latch
`timescale 1ns/1ps

module apb_access_decode import qspi_csr_pkg::*; #(
  parameter int APB_ADDR_WIDTH = 12
) (
  // Clock and reset serve the bound checkers only
  input  logic                      pclk,
  input  logic                      presetn,
  input  logic                      psel_i,
  input  logic                      penable_i,
  input  logic                      pwrite_i,
  input  logic [APB_ADDR_WIDTH-1:0] paddr_i,
  input  csr_data_t                 pwdata_i,
  input  csr_strb_t                 pstrb_i,
  input  logic                      busy_i,
  output csr_data_t                 prdata_o,
  output logic                      pready_o,
  output logic                      pslverr_o,
  csr_access_if.decode              acc
);

  logic        wr_phase;
  logic        rd_phase;
  csr_offset_t ofs;
  csr_reg_e    reg_sel;
  logic        read_only;
  logic        trig_wr;
  csr_data_t   id_rdata;

  // ----------------------------------------
  // APB phases
  // ----------------------------------------
  assign wr_phase = psel_i & penable_i & pwrite_i;
  assign rd_phase = psel_i & penable_i & ~pwrite_i;
  assign pready_o = 1'b1;

  assign ofs = paddr_i[$bits(csr_offset_t)-1:0];

  // ----------------------------------------
  // Address decode
  // ----------------------------------------
  always_comb begin
    case (ofs)
      ID_OFS:       reg_sel = REG_ID;
      CTRL_OFS:     reg_sel = REG_CTRL;
      STATUS_OFS:   reg_sel = REG_STATUS;
      INT_EN_OFS:   reg_sel = REG_INT_EN;
      INT_STAT_OFS: reg_sel = REG_INT_STAT;
      CLK_DIV_OFS:  reg_sel = REG_CLK_DIV;
      CMD_OP_OFS:   reg_sel = REG_CMD_OP;
      CMD_ADDR_OFS: reg_sel = REG_CMD_ADDR;
      default:      reg_sel = REG_NONE;
    endcase
  end

  assign read_only = (reg_sel == REG_ID) || (reg_sel == REG_STATUS);

  // Trigger bit lives in byte 1 of CTRL
  assign trig_wr = wr_phase && (reg_sel == REG_CTRL) && pstrb_i[1] && pwdata_i[CTRL_TRIG_BIT];

  // A busy trigger errors out but the rest of the CTRL write still lands
  assign pslverr_o = wr_phase && ((reg_sel == REG_NONE) || read_only || (trig_wr && busy_i));

  // ----------------------------------------
  // Access strobes to the units
  // ----------------------------------------
  // STATUS passes so the status unit can clear its done latch
  assign acc.wr_stb   = wr_phase && (reg_sel != REG_NONE) && (reg_sel != REG_ID);
  assign acc.rd_stb   = rd_phase;
  assign acc.reg_sel  = reg_sel;
  assign acc.wdata    = pwdata_i;
  assign acc.wstrb    = pstrb_i;
  assign acc.trig_req = trig_wr && !busy_i;

  // Read data merge, units return zero unless selected
  assign id_rdata = (rd_phase && (reg_sel == REG_ID)) ? CSR_ID_VALUE : '0;
  assign prdata_o = id_rdata | acc.bank_rdata | acc.stat_rdata;

endmodule

/* csr_access_if.sv */
// Decoded CSR access bundle; the APB address bus must be at least 12 bits wide
`timescale 1ns/1ps

interface csr_access_if import qspi_csr_pkg::*; #(
  parameter int APB_ADDR_WIDTH = 12
);

  // Decoder to units
  logic      wr_stb;
  logic      rd_stb;
  csr_reg_e  reg_sel;
  csr_data_t wdata;
  csr_strb_t wstrb;
  logic      trig_req;

  // Units back to decoder, zero when not selected
  csr_data_t bank_rdata;
  csr_data_t stat_rdata;

  // The decoder takes the register offset from the low bits of paddr
  initial begin
    if (APB_ADDR_WIDTH < $bits(csr_offset_t))
      $error("APB address bus narrower than the CSR window");
  end

  modport decode (
    output wr_stb, rd_stb, reg_sel, wdata, wstrb, trig_req,
    input  bank_rdata, stat_rdata
  );

  modport bank (
    input  wr_stb, rd_stb, reg_sel, wdata, wstrb, trig_req,
    output bank_rdata
  );

  modport status (
    input  wr_stb, rd_stb, reg_sel, wdata, wstrb,
    output stat_rdata
  );

endinterface

/* csr_reg_bank.sv */
// Configuration registers; cmd_start_o holds until the command engine pulses its clear
`timescale 1ns/1ps

module csr_reg_bank import qspi_csr_pkg::*; (
  input  logic        pclk,
  input  logic        presetn,
  input  logic        cmd_trigger_clr_i,
  csr_access_if.bank  acc,
  output logic        enable_o,
  output logic        xip_en_o,
  output logic        quad_en_o,
  output logic        cpol_o,
  output logic        cpha_o,
  output logic        lsb_first_o,
  output logic [2:0]  clk_div_o,
  output logic [7:0]  opcode_o,
  output csr_data_t   cmd_addr_o,
  output logic        cmd_start_o
);

  csr_data_t ctrl_q;
  csr_data_t clk_div_q;
  csr_data_t cmd_op_q;
  csr_data_t cmd_addr_q;
  csr_data_t ctrl_next;
  logic      ctrl_wr;
  logic      trig_ok;

  // ----------------------------------------
  // Register writes
  // ----------------------------------------
  always_ff @(posedge pclk or negedge presetn) begin
    if (!presetn) begin
      ctrl_q     <= CTRL_RST;
      clk_div_q  <= CLK_DIV_RST;
      cmd_op_q   <= CMD_OP_RST;
      cmd_addr_q <= CMD_ADDR_RST;
    end else if (acc.wr_stb) begin
      case (acc.reg_sel)
        REG_CTRL:     ctrl_q     <= apply_strb(ctrl_q, acc.wdata, acc.wstrb) & CTRL_WMASK;
        REG_CLK_DIV:  clk_div_q  <= apply_strb(clk_div_q, acc.wdata, acc.wstrb) & CLK_DIV_WMASK;
        REG_CMD_OP:   cmd_op_q   <= apply_strb(cmd_op_q, acc.wdata, acc.wstrb) & CMD_OP_WMASK;
        REG_CMD_ADDR: cmd_addr_q <= apply_strb(cmd_addr_q, acc.wdata, acc.wstrb);
        default: ;
      endcase
    end
  end

  // ----------------------------------------
  // Command trigger
  // ----------------------------------------
  assign ctrl_wr = acc.wr_stb && (acc.reg_sel == REG_CTRL);

  // Enable and XIP as they stand after this write, so one write can enable and trigger
  assign ctrl_next = (ctrl_wr && acc.wstrb[0]) ? acc.wdata : ctrl_q;
  assign trig_ok   = acc.trig_req && ctrl_next[CTRL_EN_BIT] && !ctrl_next[CTRL_XIP_BIT];

  always_ff @(posedge pclk or negedge presetn) begin
    if (!presetn) begin
      cmd_start_o <= 1'b0;
    end else if (cmd_trigger_clr_i) begin
      cmd_start_o <= 1'b0;
    end else if (trig_ok) begin
      cmd_start_o <= 1'b1;
    end
  end

  // Readback, trigger bit is never stored so it reads 0
  always_comb begin
    acc.bank_rdata = '0;
    if (acc.rd_stb) begin
      case (acc.reg_sel)
        REG_CTRL:     acc.bank_rdata = ctrl_q;
        REG_CLK_DIV:  acc.bank_rdata = clk_div_q;
        REG_CMD_OP:   acc.bank_rdata = cmd_op_q;
        REG_CMD_ADDR: acc.bank_rdata = cmd_addr_q;
        default:      acc.bank_rdata = '0;
      endcase
    end
  end

  // Field outputs
  assign enable_o    = ctrl_q[CTRL_EN_BIT];
  assign xip_en_o    = ctrl_q[CTRL_XIP_BIT];
  assign quad_en_o   = ctrl_q[2];
  assign cpol_o      = ctrl_q[3];
  assign cpha_o      = ctrl_q[4];
  assign lsb_first_o = ctrl_q[5];
  assign clk_div_o   = clk_div_q[2:0];
  assign opcode_o    = cmd_op_q[7:0];
  assign cmd_addr_o  = cmd_addr_q;

endmodule

/* irq_status_unit.sv */
// Interrupt and status registers; a set pulse wins over a W1C clear in the same cycle
`timescale 1ns/1ps

module irq_status_unit import qspi_csr_pkg::*; (
  input  logic          pclk,
  input  logic          presetn,
  input  logic          busy_i,
  input  logic          xip_active_i,
  input  logic          cmd_done_set_i,
  input  logic          err_set_i,
  input  logic          rx_full_set_i,
  csr_access_if.status  acc,
  output logic          irq_o
);

  irq_vec_t  int_en_q;
  irq_vec_t  int_stat_q;
  irq_vec_t  set_vec;
  irq_vec_t  clr_vec;
  csr_data_t int_en_wr;
  logic      done_q;
  logic      done_clr;

  assign set_vec = {rx_full_set_i, err_set_i, cmd_done_set_i};

  // W1C on byte 0 only
  assign clr_vec = (acc.wr_stb && (acc.reg_sel == REG_INT_STAT) && acc.wstrb[0]) ?
                   acc.wdata[$bits(irq_vec_t)-1:0] : '0;

  assign done_clr = acc.wr_stb && (acc.reg_sel == REG_STATUS) && acc.wstrb[0] && acc.wdata[0];

  assign int_en_wr = apply_strb(csr_data_t'(int_en_q), acc.wdata, acc.wstrb) & INT_EN_WMASK;

  always_ff @(posedge pclk or negedge presetn) begin
    if (!presetn) begin
      int_en_q   <= INT_EN_RST;
      int_stat_q <= '0;
      done_q     <= 1'b0;
    end else begin
      if (acc.wr_stb && (acc.reg_sel == REG_INT_EN))
        int_en_q <= int_en_wr[$bits(irq_vec_t)-1:0];
      int_stat_q <= (int_stat_q & ~clr_vec) | set_vec;
      if (cmd_done_set_i)
        done_q <= 1'b1;
      else if (done_clr)
        done_q <= 1'b0;
    end
  end

  // Readback, STATUS is done latch, xip_active and busy
  always_comb begin
    acc.stat_rdata = '0;
    if (acc.rd_stb) begin
      case (acc.reg_sel)
        REG_STATUS:   acc.stat_rdata = {28'd0, busy_i, xip_active_i, 1'b0, done_q};
        REG_INT_EN:   acc.stat_rdata = csr_data_t'(int_en_q);
        REG_INT_STAT: acc.stat_rdata = csr_data_t'(int_stat_q);
        default:      acc.stat_rdata = '0;
      endcase
    end
  end

  assign irq_o = |(int_en_q & int_stat_q);

endmodule

/* qspi_csr_assertions.sv */
// Bound to the CSR top and samples the decoder pins; only the low 12 address bits are compared
`timescale 1ns/1ps

module qspi_csr_assertions import qspi_csr_pkg::*; (
  input logic        pclk,
  input logic        presetn,
  input logic        psel_i,
  input logic        penable_i,
  input logic        pwrite_i,
  input logic [11:0] paddr_i,
  input logic [31:0] pwdata_i,
  input logic [3:0]  pstrb_i,
  input logic        busy_i,
  input logic [31:0] prdata_o,
  input logic        cmd_start_o
);

  logic rd_access;
  logic trig_access;

  assign rd_access   = psel_i && penable_i && !pwrite_i;
  assign trig_access = psel_i && penable_i && pwrite_i && (paddr_i == CTRL_OFS) &&
                       pstrb_i[1] && pwdata_i[CTRL_TRIG_BIT] && !busy_i;

  // Read data bus is quiet outside a read access phase
  a_prdata_idle: assert property (@(posedge pclk) disable iff (!presetn)
    !rd_access |-> (prdata_o == 32'h0))
    else $error("prdata_o nonzero outside a read access phase");

  // Both units stay quiet on an ID read
  a_id_read: assert property (@(posedge pclk) disable iff (!presetn)
    rd_access && (paddr_i == ID_OFS) |-> (prdata_o == CSR_ID_VALUE))
    else $error("ID read returned 0x%h", prdata_o);

  // A command start follows an APB trigger write taken while idle
  a_start_cause: assert property (@(posedge pclk) disable iff (!presetn)
    $rose(cmd_start_o) |-> $past(trig_access))
    else $error("cmd_start_o rose without a trigger write in the previous cycle");

endmodule

bind qspi_csr_top qspi_csr_assertions u_assert (
  .pclk        (u_decode.pclk),
  .presetn     (u_decode.presetn),
  .psel_i      (u_decode.psel_i),
  .penable_i   (u_decode.penable_i),
  .pwrite_i    (u_decode.pwrite_i),
  .paddr_i     (u_decode.paddr_i[11:0]),
  .pwdata_i    (u_decode.pwdata_i),
  .pstrb_i     (u_decode.pstrb_i),
  .busy_i      (u_decode.busy_i),
  .prdata_o    (u_decode.prdata_o),
  .cmd_start_o (cmd_start_o)
);

/* qspi_csr_pkg.sv */
// Shared CSR types and constants; only the low 12 address bits form the register offset
package qspi_csr_pkg;

  // ----------------------------------------
  // Data types
  // ----------------------------------------
  typedef logic [31:0] csr_data_t;
  typedef logic [3:0]  csr_strb_t;
  typedef logic [11:0] csr_offset_t;

  // Bit 0 cmd_done, bit 1 err, bit 2 rx_full
  typedef logic [2:0]  irq_vec_t;

  // Decoded target of an APB access
  typedef enum logic [3:0] {
    REG_NONE,
    REG_ID,
    REG_CTRL,
    REG_STATUS,
    REG_INT_EN,
    REG_INT_STAT,
    REG_CLK_DIV,
    REG_CMD_OP,
    REG_CMD_ADDR
  } csr_reg_e;

  // ----------------------------------------
  // Register map
  // ----------------------------------------
  localparam csr_offset_t ID_OFS       = 12'h000;
  localparam csr_offset_t CTRL_OFS     = 12'h004;
  localparam csr_offset_t STATUS_OFS   = 12'h008;
  localparam csr_offset_t INT_EN_OFS   = 12'h00C;
  localparam csr_offset_t INT_STAT_OFS = 12'h010;
  localparam csr_offset_t CLK_DIV_OFS  = 12'h014;
  localparam csr_offset_t CMD_OP_OFS   = 12'h028;
  localparam csr_offset_t CMD_ADDR_OFS = 12'h02C;

  localparam csr_data_t CSR_ID_VALUE = 32'h1A00_1081;

  // Writable bits per register
  localparam csr_data_t CTRL_WMASK    = 32'h0000_003F;
  localparam csr_data_t CLK_DIV_WMASK = 32'h0000_0007;
  localparam csr_data_t CMD_OP_WMASK  = 32'h0000_00FF;
  localparam csr_data_t INT_EN_WMASK  = 32'h0000_0007;

  // CTRL field positions
  localparam int CTRL_EN_BIT   = 0;
  localparam int CTRL_XIP_BIT  = 1;
  localparam int CTRL_TRIG_BIT = 8;

  // Reset values
  localparam csr_data_t CTRL_RST     = 32'h0;
  localparam csr_data_t CLK_DIV_RST  = 32'h0;
  localparam csr_data_t CMD_OP_RST   = 32'h0;
  localparam csr_data_t CMD_ADDR_RST = 32'h0;
  localparam irq_vec_t  INT_EN_RST   = 3'b000;

  // Replace the strobed bytes of cur with those of data
  function automatic csr_data_t apply_strb(input csr_data_t cur, input csr_data_t data,
                                           input csr_strb_t strb);
    csr_data_t res;
    res = cur;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) res[b*8 +: 8] = data[b*8 +: 8];
    end
    return res;
  endfunction

endpackage

/* qspi_csr_top.f */
qspi_csr_pkg.sv
csr_access_if.sv
apb_access_decode.sv
csr_reg_bank.sv
irq_status_unit.sv
qspi_csr_top.sv
qspi_csr_assertions.sv
tb_qspi_csr.sv

/* qspi_csr_top.sv */
// QSPI CSR block top; pready_o is tied high so every APB access completes at once
`timescale 1ns/1ps

module qspi_csr_top import qspi_csr_pkg::*; #(
  parameter int APB_ADDR_WIDTH = 12
) (
  // APB
  input  logic                      pclk,
  input  logic                      presetn,
  input  logic                      psel_i,
  input  logic                      penable_i,
  input  logic                      pwrite_i,
  input  logic [APB_ADDR_WIDTH-1:0] paddr_i,
  input  csr_data_t                 pwdata_i,
  input  csr_strb_t                 pstrb_i,
  output csr_data_t                 prdata_o,
  output logic                      pready_o,
  output logic                      pslverr_o,

  // Controller configuration
  output logic                      enable_o,
  output logic                      xip_en_o,
  output logic                      quad_en_o,
  output logic                      cpol_o,
  output logic                      cpha_o,
  output logic                      lsb_first_o,
  output logic [2:0]                clk_div_o,
  output logic [7:0]                opcode_o,
  output csr_data_t                 cmd_addr_o,

  // Command engine
  output logic                      cmd_start_o,
  input  logic                      cmd_trigger_clr_i,
  input  logic                      busy_i,
  input  logic                      xip_active_i,

  // Interrupt sources and request
  input  logic                      cmd_done_set_i,
  input  logic                      err_set_i,
  input  logic                      rx_full_set_i,
  output logic                      irq_o
);

  csr_access_if #(.APB_ADDR_WIDTH(APB_ADDR_WIDTH)) acc_if ();

  apb_access_decode #(.APB_ADDR_WIDTH(APB_ADDR_WIDTH)) u_decode (
    .pclk      (pclk),
    .presetn   (presetn),
    .psel_i    (psel_i),
    .penable_i (penable_i),
    .pwrite_i  (pwrite_i),
    .paddr_i   (paddr_i),
    .pwdata_i  (pwdata_i),
    .pstrb_i   (pstrb_i),
    .busy_i    (busy_i),
    .prdata_o  (prdata_o),
    .pready_o  (pready_o),
    .pslverr_o (pslverr_o),
    .acc       (acc_if.decode)
  );

  csr_reg_bank u_bank (
    .pclk              (pclk),
    .presetn           (presetn),
    .cmd_trigger_clr_i (cmd_trigger_clr_i),
    .acc               (acc_if.bank),
    .enable_o          (enable_o),
    .xip_en_o          (xip_en_o),
    .quad_en_o         (quad_en_o),
    .cpol_o            (cpol_o),
    .cpha_o            (cpha_o),
    .lsb_first_o       (lsb_first_o),
    .clk_div_o         (clk_div_o),
    .opcode_o          (opcode_o),
    .cmd_addr_o        (cmd_addr_o),
    .cmd_start_o       (cmd_start_o)
  );

  irq_status_unit u_status (
    .pclk           (pclk),
    .presetn        (presetn),
    .busy_i         (busy_i),
    .xip_active_i   (xip_active_i),
    .cmd_done_set_i (cmd_done_set_i),
    .err_set_i      (err_set_i),
    .rx_full_set_i  (rx_full_set_i),
    .acc            (acc_if.status),
    .irq_o          (irq_o)
  );

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the CSR testbench with Verilator 5 (needs --timing support)

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert -f qspi_csr_top.f \
     --top-module tb_qspi_csr -o sim_tb; then
  echo "Verilator build failed"
  exit 1
fi

if ! ./obj_dir/sim_tb > "$LOG" 2>&1; then
  cat "$LOG"
  echo "Simulation exited with an error status"
  exit 1
fi

cat "$LOG"

if grep -q "STATUS: FAIL" "$LOG"; then
  exit 1
fi
exit 0

/* tb_qspi_csr.sv */
// Directed CSR testbench; 12-bit APB address, one idle cycle between transfers
`timescale 1ns/1ps

module tb_qspi_csr import qspi_csr_pkg::*; ();

  localparam int TIMEOUT_CYCLES = 3000;

  logic        pclk;
  logic        presetn;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [11:0] paddr;
  csr_data_t   pwdata;
  csr_strb_t   pstrb;
  csr_data_t   prdata;
  logic        pready;
  logic        pslverr;
  logic        enable;
  logic        xip_en;
  logic        quad_en;
  logic        cpol;
  logic        cpha;
  logic        lsb_first;
  logic [2:0]  clk_div;
  logic [7:0]  opcode;
  csr_data_t   cmd_addr;
  logic        cmd_start;
  logic        cmd_trigger_clr;
  logic        busy;
  logic        xip_active;
  logic        cmd_done_set;
  logic        err_set;
  logic        rx_full_set;
  logic        irq;

  // Reference model of the register contents
  csr_data_t ctrl_m;
  csr_data_t clk_div_m;
  csr_data_t op_m;
  csr_data_t addr_m;
  csr_data_t int_en_m;
  csr_data_t int_stat_m;
  logic      done_m;
  int        errors;
  int        cycles;

  qspi_csr_top #(.APB_ADDR_WIDTH(12)) dut0 (
    .pclk              (pclk),
    .presetn           (presetn),
    .psel_i            (psel),
    .penable_i         (penable),
    .pwrite_i          (pwrite),
    .paddr_i           (paddr),
    .pwdata_i          (pwdata),
    .pstrb_i           (pstrb),
    .prdata_o          (prdata),
    .pready_o          (pready),
    .pslverr_o         (pslverr),
    .enable_o          (enable),
    .xip_en_o          (xip_en),
    .quad_en_o         (quad_en),
    .cpol_o            (cpol),
    .cpha_o            (cpha),
    .lsb_first_o       (lsb_first),
    .clk_div_o         (clk_div),
    .opcode_o          (opcode),
    .cmd_addr_o        (cmd_addr),
    .cmd_start_o       (cmd_start),
    .cmd_trigger_clr_i (cmd_trigger_clr),
    .busy_i            (busy),
    .xip_active_i      (xip_active),
    .cmd_done_set_i    (cmd_done_set),
    .err_set_i         (err_set),
    .rx_full_set_i     (rx_full_set),
    .irq_o             (irq)
  );

  initial begin
    pclk = 1'b0;
    forever #10 pclk = ~pclk;
  end

  // Watchdog well beyond the length of all tests
  initial begin
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge pclk);
      cycles++;
    end
    $display("Timeout: tests did not finish within %0d cycles, %0d errors so far",
             TIMEOUT_CYCLES, errors);
    $display("STATUS: FAIL");
    $finish;
  end

  // ----------------------------------------
  // Helpers
  // ----------------------------------------
  task automatic check_eq(input string name, input csr_data_t act, input csr_data_t exp);
    if (act !== exp) begin
      $display("ERR %s got 0x%h expected 0x%h", name, act, exp);
      errors++;
    end
  endtask

  // Strobed bytes come from data, the rest stay
  function automatic csr_data_t merge_bytes(input csr_data_t old, input csr_data_t data,
                                            input csr_strb_t strb);
    csr_data_t keep;
    keep = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
    return (data & keep) | (old & ~keep);
  endfunction

  task automatic apb_write(input logic [11:0] addr, input csr_data_t data,
                           input csr_strb_t strb, input logic exp_err);
    @(negedge pclk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    pstrb   = strb;
    @(negedge pclk);
    penable = 1'b1;
    #1;
    // Zero wait state, the access phase is the last
    check_eq("pready_o", 32'(pready), 32'h1);
    check_eq("pslverr_o", 32'(pslverr), 32'(exp_err));
    @(negedge pclk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_read(input logic [11:0] addr, input csr_data_t exp, input logic exp_err);
    @(negedge pclk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = addr;
    @(negedge pclk);
    penable = 1'b1;
    #1;
    check_eq("pready_o", 32'(pready), 32'h1);
    check_eq("prdata_o", prdata, exp);
    check_eq("pslverr_o", 32'(pslverr), 32'(exp_err));
    @(negedge pclk);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic check_outputs();
    check_eq("ctrl fields", 32'({lsb_first, cpha, cpol, quad_en, xip_en, enable}),
             ctrl_m & 32'h3F);
    check_eq("clk_div_o", 32'(clk_div), clk_div_m & 32'h7);
    check_eq("opcode_o", 32'(opcode), op_m & 32'hFF);
    check_eq("cmd_addr_o", cmd_addr, addr_m);
    check_eq("irq_o", 32'(irq), 32'(|(int_en_m[2:0] & int_stat_m[2:0])));
  endtask

  task automatic read_all_regs();
    apb_read(CTRL_OFS, ctrl_m, 1'b0);
    apb_read(CLK_DIV_OFS, clk_div_m, 1'b0);
    apb_read(CMD_OP_OFS, op_m, 1'b0);
    apb_read(CMD_ADDR_OFS, addr_m, 1'b0);
    apb_read(INT_EN_OFS, int_en_m, 1'b0);
    apb_read(INT_STAT_OFS, int_stat_m, 1'b0);
    apb_read(STATUS_OFS, {28'd0, busy, xip_active, 1'b0, done_m}, 1'b0);
  endtask

  // One-cycle pulse on an interrupt source, 0 cmd_done, 1 err, 2 rx_full
  task automatic pulse_irq_src(input int idx);
    @(negedge pclk);
    cmd_done_set = (idx == 0);
    err_set      = (idx == 1);
    rx_full_set  = (idx == 2);
    @(negedge pclk);
    cmd_done_set = 1'b0;
    err_set      = 1'b0;
    rx_full_set  = 1'b0;
    int_stat_m[idx] = 1'b1;
    if (idx == 0)
      done_m = 1'b1;
    check_outputs();
  endtask

  // ----------------------------------------
  // Tests
  // ----------------------------------------
  task automatic reset_and_id();
    apb_read(ID_OFS, 32'h1A00_1081, 1'b0);
    read_all_regs();
    check_outputs();
    check_eq("cmd_start_o", 32'(cmd_start), 32'h0);
  endtask

  task automatic masked_writes();
    csr_data_t data;
    csr_strb_t strb;
    for (int i = 0; i < 6; i++) begin
      // Trigger bit kept clear here
      data = $urandom() & ~32'h100;
      strb = 4'($urandom());
      apb_write(CTRL_OFS, data, strb, 1'b0);
      ctrl_m = merge_bytes(ctrl_m, data, strb) & 32'h3F;
      data = $urandom();
      strb = 4'($urandom());
      apb_write(CLK_DIV_OFS, data, strb, 1'b0);
      clk_div_m = merge_bytes(clk_div_m, data, strb) & 32'h7;
      data = $urandom();
      strb = 4'($urandom());
      apb_write(CMD_OP_OFS, data, strb, 1'b0);
      op_m = merge_bytes(op_m, data, strb) & 32'hFF;
      data = $urandom();
      strb = 4'($urandom());
      apb_write(CMD_ADDR_OFS, data, strb, 1'b0);
      addr_m = merge_bytes(addr_m, data, strb);
      data = $urandom();
      strb = 4'($urandom());
      apb_write(INT_EN_OFS, data, strb, 1'b0);
      int_en_m = merge_bytes(int_en_m, data, strb) & 32'h7;
      check_outputs();
      read_all_regs();
    end
    check_eq("cmd_start_o", 32'(cmd_start), 32'h0);
  endtask

  task automatic access_errors();
    // Done latch set first so a STATUS write without bit 0 must leave it
    pulse_irq_src(0);
    apb_write(12'h030, $urandom(), 4'hF, 1'b1);
    apb_write(ID_OFS, $urandom(), 4'hF, 1'b1);
    // Bit 0 clear, so the done latch is left alone
    apb_write(STATUS_OFS, $urandom() & ~32'h1, 4'hF, 1'b1);
    apb_read(ID_OFS, 32'h1A00_1081, 1'b0);
    read_all_regs();
    check_outputs();
    apb_read(12'h030, 32'h0, 1'b0);
    apb_read(12'hFFC, 32'h0, 1'b0);
  endtask

  task automatic command_trigger();
    apb_write(CTRL_OFS, 32'h0, 4'hF, 1'b0);
    ctrl_m = 32'h0;
    // Enable and trigger in one write
    apb_write(CTRL_OFS, 32'h101, 4'h3, 1'b0);
    ctrl_m = 32'h1;
    check_eq("cmd_start_o", 32'(cmd_start), 32'h1);
    repeat (3) @(negedge pclk);
    check_eq("cmd_start_o", 32'(cmd_start), 32'h1);
    apb_read(CTRL_OFS, ctrl_m, 1'b0);
    cmd_trigger_clr = 1'b1;
    @(negedge pclk);
    cmd_trigger_clr = 1'b0;
    check_eq("cmd_start_o", 32'(cmd_start), 32'h0);
    // XIP set blocks the start
    apb_write(CTRL_OFS, 32'h103, 4'h3, 1'b0);
    ctrl_m = 32'h3;
    @(negedge pclk);
    check_eq("cmd_start_o", 32'(cmd_start), 32'h0);
    // Enable clear blocks the start
    apb_write(CTRL_OFS, 32'h100, 4'h3, 1'b0);
    ctrl_m = 32'h0;
    @(negedge pclk);
    check_eq("cmd_start_o", 32'(cmd_start), 32'h0);
    // Busy gives an error, other CTRL bits still land
    busy = 1'b1;
    apb_write(CTRL_OFS, 32'h105, 4'h3, 1'b1);
    ctrl_m = 32'h5;
    @(negedge pclk);
    check_eq("cmd_start_o", 32'(cmd_start), 32'h0);
    apb_read(CTRL_OFS, ctrl_m, 1'b0);
    busy = 1'b0;
    check_outputs();
  endtask

  task automatic interrupt_flow();
    apb_write(INT_STAT_OFS, 32'h7, 4'h1, 1'b0);
    int_stat_m = 32'h0;
    apb_write(INT_EN_OFS, 32'hFFFF_FFFD, 4'hF, 1'b0);
    int_en_m = 32'h5;
    check_outputs();
    pulse_irq_src(1);
    check_eq("irq_o", 32'(irq), 32'h0);
    pulse_irq_src(0);
    pulse_irq_src(2);
    apb_read(INT_STAT_OFS, 32'h7, 1'b0);
    apb_write(INT_STAT_OFS, 32'h1, 4'h1, 1'b0);
    int_stat_m = 32'h6;
    apb_read(INT_STAT_OFS, int_stat_m, 1'b0);
    check_outputs();
    // rx_full was the last enabled source
    apb_write(INT_STAT_OFS, 32'h4, 4'h1, 1'b0);
    int_stat_m = 32'h2;
    check_outputs();
    check_eq("irq_o", 32'(irq), 32'h0);
    apb_write(INT_STAT_OFS, 32'h2, 4'h1, 1'b0);
    int_stat_m = 32'h0;
    apb_read(INT_STAT_OFS, int_stat_m, 1'b0);
  endtask

  task automatic status_flags();
    busy = 1'b1;
    apb_read(STATUS_OFS, {28'd0, busy, xip_active, 1'b0, done_m}, 1'b0);
    busy       = 1'b0;
    xip_active = 1'b1;
    apb_read(STATUS_OFS, {28'd0, busy, xip_active, 1'b0, done_m}, 1'b0);
    xip_active = 1'b0;
    // Still flagged as read-only, but bit 0 clears the done latch
    apb_write(STATUS_OFS, 32'h1, 4'h1, 1'b1);
    done_m = 1'b0;
    apb_read(STATUS_OFS, 32'h0, 1'b0);
    pulse_irq_src(0);
    apb_read(STATUS_OFS, 32'h1, 1'b0);
    apb_write(STATUS_OFS, 32'h1, 4'h1, 1'b1);
    done_m = 1'b0;
    read_all_regs();
  endtask

  // ----------------------------------------
  // Main sequence
  // ----------------------------------------
  initial begin
    void'($urandom(32'hf5c2_0e50));
    errors          = 0;
    presetn         = 1'b0;
    psel            = 1'b0;
    penable         = 1'b0;
    pwrite          = 1'b0;
    paddr           = '0;
    pwdata          = '0;
    pstrb           = '0;
    cmd_trigger_clr = 1'b0;
    busy            = 1'b0;
    xip_active      = 1'b0;
    cmd_done_set    = 1'b0;
    err_set         = 1'b0;
    rx_full_set     = 1'b0;
    ctrl_m          = '0;
    clk_div_m       = '0;
    op_m            = '0;
    addr_m          = '0;
    int_en_m        = '0;
    int_stat_m      = '0;
    done_m          = 1'b0;
    repeat (16) @(negedge pclk);
    presetn = 1'b1;

    reset_and_id();
    masked_writes();
    access_errors();
    command_trigger();
    interrupt_flow();
    status_flags();

    $display("Tests done after %0d cycles with %0d errors", cycles, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule
